// File: Bender.yml
package:
  name: vmem_subsystem

sources:
  # Design sources
  - target: any(rtl, test)
    files:
      - logic/vmem_pkg.sv
      - logic/vmem_lane_align.sv
      - logic/vmem_address_scheduler.sv
      - logic/vmem_memory_stage.sv
      - logic/vmem_scratchpad.sv
      - logic/vmem_subsystem.sv

  # Simulation only
  - target: test
    files:
      - bench/vmem_checker.sv
      - bench/vmem_tb.sv

// File: bench/vmem_checker.sv
`timescale 1ns/1ps
`default_nettype none

/*
  Vector memory stage protocol checker
  Wishbone request rules and writeback latch rules, bound into
  every instance of the memory stage.
*/
module vmem_checker (
  input logic                 CLK,
  input logic                 nRST,
  input logic                 start,
  input logic                 stall,
  input logic                 cyc,
  input logic                 stb,
  input logic                 we,
  input vmem_pkg::addr_t      adr,
  input vmem_pkg::sel_t       sel,
  input vmem_pkg::word_t      dat_w,
  input logic                 ack,
  input logic                 wb_valid,
  input vmem_pkg::lane_mask_t wb_exc
);

  int unsigned violations = 0;  // Read by the testbench at the end

  stb_with_cyc: assert property (@(posedge CLK) disable iff (!nRST) stb |-> cyc)
    else begin
      $error("stb high without cyc");
      violations++;
    end

  // Request must not move while the slave is still working on it
  request_held: assert property (@(posedge CLK) disable iff (!nRST)
      (stb && !ack) |=> (stb && $stable(adr) && $stable(sel) && $stable(we) &&
                         $stable(dat_w)))
    else begin
      $error("Wishbone request changed before ack");
      violations++;
    end

  idle_after_ack: assert property (@(posedge CLK) disable iff (!nRST) ack |=> !stb)
    else begin
      $error("stb still high in the cycle after ack");
      violations++;
    end

  no_retire_on_start: assert property (@(posedge CLK) disable iff (!nRST)
      (start && stall) |=> !wb_valid)
    else begin
      $error("Writeback latch loaded in a scheduler start cycle");
      violations++;
    end

  exc_needs_valid: assert property (@(posedge CLK) disable iff (!nRST)
      (|wb_exc) |-> wb_valid)
    else begin
      $error("wb_exc set without wb_valid");
      violations++;
    end

endmodule

bind vmem_memory_stage vmem_checker u_checker (
  .CLK      (CLK),
  .nRST     (nRST),
  .start    (start),
  .stall    (stall),
  .cyc      (cyc),
  .stb      (stb),
  .we       (we),
  .adr      (adr),
  .sel      (sel),
  .dat_w    (dat_w),
  .ack      (ack),
  .wb_valid (wb_valid),
  .wb_exc   (wb_exc)
);

`default_nettype wire

// File: bench/vmem_tb.sv
`timescale 1ns/1ps
`default_nettype none

/*
  Testbench for the vector memory subsystem
  Drives loads, stores and pass-through operations into the memory
  stage, mirrors every store in a shadow memory and checks each
  writeback against a reference model of the lane rules.
*/
module vmem_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 5;
  localparam int MEM_WORDS    = 256;
  localparam int WAIT_STATES  = 1;
  localparam int SEED         = 53755;
  localparam int RANDOM_OPS   = 300;
  localparam int TOTAL_OPS    = MEM_WORDS / 2 + 8 + 18 + 8 + 6 + 6 + RANDOM_OPS;
  localparam int OP_CYCLES    = 2 * (WAIT_STATES + 2) + 4;  // Worst case per operation
  localparam int LIMIT_CYCLES = TOTAL_OPS * OP_CYCLES + 200;

  typedef struct {
    vmem_pkg::vreg_t      vd;
    vmem_pkg::word_t      data0;
    vmem_pkg::word_t      data1;
    vmem_pkg::lane_mask_t mask;
    vmem_pkg::lane_mask_t exc;
  } result_t;

  logic                 CLK = 1'b0;
  logic                 nRST;
  logic                 valid;
  logic                 load;
  logic                 store;
  vmem_pkg::eew_e       eew;
  vmem_pkg::lane_mask_t lane_mask;
  vmem_pkg::addr_t      addr0;
  vmem_pkg::addr_t      addr1;
  vmem_pkg::word_t      sdata0;
  vmem_pkg::word_t      sdata1;
  vmem_pkg::word_t      alu0;
  vmem_pkg::word_t      alu1;
  vmem_pkg::vreg_t      vd;
  logic                 flush;
  logic                 stall;
  logic                 wb_valid;
  vmem_pkg::vreg_t      wb_vd;
  vmem_pkg::word_t      wb_data0;
  vmem_pkg::word_t      wb_data1;
  vmem_pkg::lane_mask_t wb_mask;
  vmem_pkg::lane_mask_t wb_exc;

  vmem_pkg::word_t shadow [MEM_WORDS];  // Mirror of the scratchpad
  result_t         expected_q[$];
  result_t         want;
  vmem_pkg::vreg_t next_vd = '0;
  int              errors = 0;
  int              checks = 0;
  int              ops_issued = 0;

  vmem_subsystem #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) dut_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .valid     (valid),
    .load      (load),
    .store     (store),
    .eew       (eew),
    .lane_mask (lane_mask),
    .addr0     (addr0),
    .addr1     (addr1),
    .sdata0    (sdata0),
    .sdata1    (sdata1),
    .alu0      (alu0),
    .alu1      (alu1),
    .vd        (vd),
    .flush     (flush),
    .stall     (stall),
    .wb_valid  (wb_valid),
    .wb_vd     (wb_vd),
    .wb_data0  (wb_data0),
    .wb_data1  (wb_data1),
    .wb_mask   (wb_mask),
    .wb_exc    (wb_exc)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  function automatic int element_bytes(input vmem_pkg::eew_e e);
    case (e)
      vmem_pkg::EEW8:  return 1;
      vmem_pkg::EEW16: return 2;
      default:         return 4;
    endcase
  endfunction

  function automatic logic lane_misaligned(input vmem_pkg::addr_t a, input vmem_pkg::eew_e e);
    return (a % element_bytes(e)) != 0;
  endfunction

  function automatic int word_index(input vmem_pkg::addr_t a);
    return (a >> 2) % MEM_WORDS;
  endfunction

  // Initial contents are a hash of the full byte address
  function automatic vmem_pkg::word_t fill_word(input vmem_pkg::addr_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  // Picks the element bytes out of a word one by one
  function automatic vmem_pkg::word_t element_of(input vmem_pkg::word_t w, input logic [1:0] off,
                                                 input vmem_pkg::eew_e e);
    vmem_pkg::word_t r;
    int              pos;
    r   = '0;
    pos = off;
    for (int k = 0; k < element_bytes(e); k++) begin
      r[8*k +: 8] = w[8*(pos+k) +: 8];
    end
    return r;
  endfunction

  // Rising edges from valid up to and including acceptance
  function automatic int accept_edges(input logic ld, input logic st, input vmem_pkg::eew_e e,
                                      input vmem_pkg::lane_mask_t m, input vmem_pkg::addr_t a0,
                                      input vmem_pkg::addr_t a1);
    int accesses;
    int edges;
    accesses = 0;
    for (int lane = 0; lane < vmem_pkg::NUM_LANES; lane++) begin
      if (m[lane] && !lane_misaligned((lane == 0) ? a0 : a1, e)) begin
        accesses++;
      end
    end
    if (!(ld || st)) begin
      edges = 1;   // Straight into the latch
    end else if (accesses == 0) begin
      edges = 2;   // Start cycle, then done
    end else begin
      edges = 1 + accesses * (WAIT_STATES + 3);  // Request to ack, plus idle cycle
    end
    return edges;
  endfunction

  function automatic result_t reference_result(input logic ld, input logic st,
      input vmem_pkg::eew_e e, input vmem_pkg::lane_mask_t m, input vmem_pkg::addr_t a0,
      input vmem_pkg::addr_t a1, input vmem_pkg::word_t x0, input vmem_pkg::word_t x1,
      input vmem_pkg::vreg_t v);
    result_t         r;
    vmem_pkg::addr_t a;
    vmem_pkg::word_t elem;
    logic            bad;
    r.vd    = v;
    r.mask  = m;
    r.exc   = '0;
    r.data0 = x0;   // Pass-through values unless memory op
    r.data1 = x1;
    if (ld || st) begin
      r.data0 = '0;
      r.data1 = '0;
      for (int lane = 0; lane < vmem_pkg::NUM_LANES; lane++) begin
        a   = (lane == 0) ? a0 : a1;
        bad = lane_misaligned(a, e);
        r.exc[lane] = m[lane] & bad;
        if (ld && m[lane] && !bad) begin
          elem = element_of(shadow[word_index(a)], a[1:0], e);
          if (lane == 0) begin
            r.data0 = elem;
          end else begin
            r.data1 = elem;
          end
        end
      end
    end
    return r;
  endfunction

  task automatic shadow_store(input vmem_pkg::eew_e e, input vmem_pkg::lane_mask_t m,
                              input vmem_pkg::addr_t a0, input vmem_pkg::addr_t a1,
                              input vmem_pkg::word_t d0, input vmem_pkg::word_t d1);
    vmem_pkg::addr_t a;
    vmem_pkg::word_t d;
    int              pos;
    for (int lane = 0; lane < vmem_pkg::NUM_LANES; lane++) begin
      a   = (lane == 0) ? a0 : a1;
      d   = (lane == 0) ? d0 : d1;
      pos = a[1:0];
      if (m[lane] && !lane_misaligned(a, e)) begin
        for (int k = 0; k < element_bytes(e); k++) begin
          shadow[word_index(a)][8*(pos+k) +: 8] = d[8*k +: 8];
        end
      end
    end
  endtask

  function automatic vmem_pkg::addr_t random_address(input vmem_pkg::eew_e e);
    vmem_pkg::addr_t a;
    a = $urandom_range(MEM_WORDS * 4 - 1);
    if ($urandom_range(3) != 0) begin
      a = a & ~vmem_pkg::addr_t'(element_bytes(e) - 1);  // Mostly aligned
    end
    return a;
  endfunction

  // Called on a falling edge and returns on the falling edge after acceptance
  task automatic issue_op(input logic ld, input logic st, input vmem_pkg::eew_e e,
                          input vmem_pkg::lane_mask_t m, input vmem_pkg::addr_t a0,
                          input vmem_pkg::addr_t a1, input vmem_pkg::word_t d0,
                          input vmem_pkg::word_t d1, input logic kill);
    int edges;
    int need_edges;
    valid     = 1'b1;
    load      = ld;
    store     = st;
    eew       = e;
    lane_mask = m;
    addr0     = a0;
    addr1     = a1;
    if (ld || st) begin
      sdata0 = d0;
      sdata1 = d1;
      alu0   = $urandom();
      alu1   = $urandom();
    end else begin
      alu0   = d0;
      alu1   = d1;
      sdata0 = $urandom();
      sdata1 = $urandom();
    end
    vd      = next_vd;
    flush   = kill;   // Held up to the retire edge
    next_vd = next_vd + 1'b1;
    if (!kill) begin
      expected_q.push_back(reference_result(ld, st, e, m, a0, a1, alu0, alu1, vd));
    end
    if (st) begin
      shadow_store(e, m, a0, a1, d0, d1);  // A flushed store still writes
    end
    need_edges = accept_edges(ld, st, e, m, a0, a1);
    ops_issued++;
    edges = 0;
    do begin
      @(posedge CLK);
      edges++;
    end while (stall);
    check_value("stall length", edges, need_edges);
    @(negedge CLK);
    flush = 1'b0;
  endtask

  task automatic drain();
    valid = 1'b0;
    load  = 1'b0;
    store = 1'b0;
    flush = 1'b0;
    while (expected_q.size() != 0) begin
      @(negedge CLK);
    end
    repeat (2) @(negedge CLK);  // Catch stray writebacks
  endtask

  task automatic report_test(input string name, input int op_start, input int err_start);
    $display("%s: %0d operations, %0d mismatches", name, ops_issued - op_start,
             errors - err_start);
  endtask

  task automatic check_value(input string name, input vmem_pkg::word_t got,
                             input vmem_pkg::word_t exp);
    checks++;
    assert (got === exp)
      else begin
        $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        errors++;
      end
  endtask

  // Registered outputs are stable at the falling edge
  always @(negedge CLK) begin
    if (nRST && wb_valid) begin
      assert (expected_q.size() != 0)
        else begin
          $display("Writeback for v%0d arrived with no operation outstanding", wb_vd);
          errors++;
        end
      if (expected_q.size() != 0) begin
        want = expected_q.pop_front();
        check_value("wb_vd", wb_vd, want.vd);
        check_value("wb_data0", wb_data0, want.data0);
        check_value("wb_data1", wb_data1, want.data1);
        check_value("wb_mask", wb_mask, want.mask);
        check_value("wb_exc", wb_exc, want.exc);
      end
    end
  end

  initial begin : watchdog
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles, writeback never completed", LIMIT_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial begin : stimulus
    int                   op0;
    int                   err0;
    int                   kind;
    int                   checker_fails;
    vmem_pkg::addr_t      a0;
    vmem_pkg::addr_t      a1;
    vmem_pkg::eew_e       e;
    vmem_pkg::lane_mask_t m;
    void'($urandom(SEED));
    nRST      = 1'b0;
    valid     = 1'b0;
    load      = 1'b0;
    store     = 1'b0;
    eew       = vmem_pkg::EEW8;
    lane_mask = '0;
    addr0     = '0;
    addr1     = '0;
    sdata0    = '0;
    sdata1    = '0;
    alu0      = '0;
    alu1      = '0;
    vd        = '0;
    flush     = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;

    // Whole scratchpad written through the bus first
    op0 = ops_issued;
    err0 = errors;
    for (int i = 0; i < MEM_WORDS / 2; i++) begin
      a0 = 8 * i;
      a1 = 8 * i + 4;
      issue_op(1'b0, 1'b1, vmem_pkg::EEW32, 2'b11, a0, a1, fill_word(a0), fill_word(a1),
               1'b0);
    end
    drain();
    report_test("preload", op0, err0);

    op0 = ops_issued;
    err0 = errors;
    for (int k = 0; k < 8; k++) begin
      a0 = 32'h40 + 16 * (k % 4);
      a1 = a0 + 32'h208;
      issue_op(k >= 4, k < 4, vmem_pkg::EEW32, 2'b11, a0, a1, $urandom(), $urandom(), 1'b0);
    end
    drain();
    report_test("word stores and loads", op0, err0);

    op0 = ops_issued;
    err0 = errors;
    for (int off = 0; off < 4; off++) begin
      a0 = 32'h300 + off;
      a1 = 32'h304 + (3 - off);
      issue_op(1'b0, 1'b1, vmem_pkg::EEW8, 2'b11, a0, a1, $urandom(), $urandom(), 1'b0);
      issue_op(1'b1, 1'b0, vmem_pkg::EEW8, 2'b11, a0, a1, '0, '0, 1'b0);
      issue_op(1'b1, 1'b0, vmem_pkg::EEW32, 2'b11, a0 & ~32'h3, a1 & ~32'h3, '0, '0, 1'b0);
    end
    for (int off = 0; off < 4; off += 2) begin
      a0 = 32'h310 + off;
      a1 = 32'h314 + (2 - off);
      issue_op(1'b0, 1'b1, vmem_pkg::EEW16, 2'b11, a0, a1, $urandom(), $urandom(), 1'b0);
      issue_op(1'b1, 1'b0, vmem_pkg::EEW16, 2'b11, a0, a1, '0, '0, 1'b0);
      issue_op(1'b1, 1'b0, vmem_pkg::EEW32, 2'b11, a0 & ~32'h3, a1 & ~32'h3, '0, '0, 1'b0);
    end
    drain();
    report_test("narrow elements", op0, err0);

    op0 = ops_issued;
    err0 = errors;
    issue_op(1'b1, 1'b0, vmem_pkg::EEW32, 2'b01, 32'h380, 32'h384, '0, '0, 1'b0);
    issue_op(1'b1, 1'b0, vmem_pkg::EEW32, 2'b10, 32'h380, 32'h384, '0, '0, 1'b0);
    issue_op(1'b0, 1'b1, vmem_pkg::EEW32, 2'b11, 32'h391, 32'h398, $urandom(), $urandom(), 1'b0);
    issue_op(1'b1, 1'b0, vmem_pkg::EEW32, 2'b11, 32'h390, 32'h398, '0, '0, 1'b0);
    issue_op(1'b0, 1'b1, vmem_pkg::EEW16, 2'b11, 32'h3a2, 32'h3a5, $urandom(), $urandom(), 1'b0);
    issue_op(1'b1, 1'b0, vmem_pkg::EEW32, 2'b11, 32'h3a0, 32'h3a4, '0, '0, 1'b0);
    issue_op(1'b1, 1'b0, vmem_pkg::EEW16, 2'b11, 32'h3b1, 32'h3b3, '0, '0, 1'b0);
    issue_op(1'b0, 1'b1, vmem_pkg::EEW32, 2'b00, 32'h3b0, 32'h3b4, $urandom(), $urandom(), 1'b0);
    drain();
    report_test("lane mask and misalignment", op0, err0);

    op0 = ops_issued;
    err0 = errors;
    issue_op(1'b0, 1'b0, vmem_pkg::EEW32, 2'b11, '0, '0, $urandom(), $urandom(), 1'b0);
    issue_op(1'b0, 1'b1, vmem_pkg::EEW32, 2'b11, 32'h200, 32'h204, $urandom(), $urandom(), 1'b0);
    issue_op(1'b0, 1'b0, vmem_pkg::EEW8, 2'b11, '0, '0, $urandom(), $urandom(), 1'b0);
    issue_op(1'b1, 1'b0, vmem_pkg::EEW32, 2'b11, 32'h200, 32'h204, '0, '0, 1'b0);
    issue_op(1'b0, 1'b0, vmem_pkg::EEW16, 2'b01, '0, '0, $urandom(), $urandom(), 1'b0);
    issue_op(1'b0, 1'b0, vmem_pkg::EEW32, 2'b00, '0, '0, $urandom(), $urandom(), 1'b0);
    drain();
    report_test("pass-through", op0, err0);

    op0 = ops_issued;
    err0 = errors;
    issue_op(1'b0, 1'b0, vmem_pkg::EEW32, 2'b11, '0, '0, $urandom(), $urandom(), 1'b1);
    issue_op(1'b1, 1'b0, vmem_pkg::EEW32, 2'b11, 32'h210, 32'h214, '0, '0, 1'b0);
    issue_op(1'b0, 1'b1, vmem_pkg::EEW16, 2'b11, 32'h212, 32'h216, $urandom(), $urandom(), 1'b1);
    issue_op(1'b1, 1'b0, vmem_pkg::EEW32, 2'b11, 32'h210, 32'h214, '0, '0, 1'b0);
    issue_op(1'b1, 1'b0, vmem_pkg::EEW8, 2'b11, 32'h211, 32'h215, '0, '0, 1'b1);
    issue_op(1'b0, 1'b0, vmem_pkg::EEW32, 2'b10, '0, '0, $urandom(), $urandom(), 1'b0);
    drain();
    report_test("flush", op0, err0);

    op0 = ops_issued;
    err0 = errors;
    for (int n = 0; n < RANDOM_OPS; n++) begin
      kind = $urandom_range(2);   // Load, store or pass-through
      e    = vmem_pkg::eew_e'($urandom_range(2));
      m    = $urandom_range(3);
      a0   = random_address(e);
      a1   = random_address(e);
      issue_op(kind == 0, kind == 1, e, m, a0, a1, $urandom(), $urandom(), 1'b0);
    end
    drain();
    report_test("random mix", op0, err0);

    checker_fails = dut_i.u_stage.u_checker.violations;
    $display("Totals: %0d operations, %0d checks, %0d mismatches, %0d assertion failures",
             ops_issued, checks, errors, checker_fails);
    if (errors == 0 && checker_fails == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
logic/vmem_pkg.sv
logic/vmem_lane_align.sv
logic/vmem_address_scheduler.sv
logic/vmem_memory_stage.sv
logic/vmem_scratchpad.sv
logic/vmem_subsystem.sv
bench/vmem_checker.sv
bench/vmem_tb.sv

// File: logic/vmem_address_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

/*
  Vector load/store address scheduler
  Issues the word accesses of the active lanes one after the other as a
  Wishbone classic master, lane 0 first. Lanes that are masked off or
  misaligned get no access, an active misaligned lane raises its
  exception bit. Stores replicate the element over the word and select
  only its bytes.
*/
module vmem_address_scheduler (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 start,
  input  logic                 load,
  input  logic                 store,
  input  vmem_pkg::eew_e       eew,
  input  vmem_pkg::lane_mask_t lane_mask,
  input  vmem_pkg::addr_t      addr0,
  input  vmem_pkg::addr_t      addr1,
  input  vmem_pkg::word_t      sdata0,
  input  vmem_pkg::word_t      sdata1,
  output logic                 busy,
  output logic                 done,
  output vmem_pkg::lane_mask_t exc,
  output logic                 arrived0,
  output logic                 arrived1,
  output logic                 cyc,
  output logic                 stb,
  output logic                 we,
  output vmem_pkg::addr_t      adr,
  output vmem_pkg::sel_t       sel,
  output vmem_pkg::word_t      dat_w,
  input  logic                 ack
);

  typedef enum logic [2:0] {
    IDLE,
    LANE0,
    GAP,     // Bus idle between the two lanes
    LANE1,
    FINISH
  } state_e;

  state_e               state, next_state;
  vmem_pkg::lane_mask_t misal;
  vmem_pkg::lane_mask_t go;        // Lanes that need a bus access
  logic                 lane_sel;  // Lane 1 on the bus
  vmem_pkg::addr_t      cur_addr;
  vmem_pkg::word_t      cur_data;
  vmem_pkg::sel_t       store_sel;

  assign misal[0] = vmem_pkg::misaligned(addr0, eew);
  assign misal[1] = vmem_pkg::misaligned(addr1, eew);
  assign go       = lane_mask & ~misal;
  assign exc      = (load | store) ? (lane_mask & misal) : '0;

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (start) begin
          if (go[0]) begin
            next_state = LANE0;
          end else if (go[1]) begin
            next_state = LANE1;  // Bus already idle, no gap needed
          end else begin
            next_state = FINISH;
          end
        end
      end
      LANE0: begin
        if (ack) begin
          next_state = go[1] ? GAP : FINISH;
        end
      end
      GAP: begin
        next_state = LANE1;
      end
      LANE1: begin
        if (ack) begin
          next_state = FINISH;
        end
      end
      default: begin
        next_state = IDLE;   // FINISH lasts one cycle
      end
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (nRST == 0) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  assign busy     = (state != IDLE);
  assign done     = (state == FINISH);
  assign arrived0 = (state == LANE0) & ack;
  assign arrived1 = (state == LANE1) & ack;

  // Request held from state and stable upstream inputs until ack
  assign cyc      = (state == LANE0) || (state == LANE1);
  assign stb      = cyc;
  assign we       = cyc & store;
  assign lane_sel = (state == LANE1);
  assign cur_addr = lane_sel ? addr1 : addr0;
  assign cur_data = lane_sel ? sdata1 : sdata0;
  assign adr      = {cur_addr[31:2], 2'b00};

  always_comb begin
    case (eew)
      vmem_pkg::EEW8: begin
        store_sel = 4'b0001 << cur_addr[1:0];
        dat_w     = {4{cur_data[7:0]}};
      end
      vmem_pkg::EEW16: begin
        store_sel = 4'b0011 << cur_addr[1:0];
        dat_w     = {2{cur_data[15:0]}};
      end
      default: begin
        store_sel = 4'b1111;
        dat_w     = cur_data;
      end
    endcase
  end

  assign sel = store ? store_sel : 4'b1111;  // Loads fetch the whole word

endmodule

`default_nettype wire

// File: logic/vmem_lane_align.sv
`timescale 1ns/1ps
`default_nettype none

/*
  Load lane aligner
  Moves one element of a returned bus word down to bit 0 using the
  byte offset of its address, then zero-extends it to a full word.
*/
module vmem_lane_align (
  input  vmem_pkg::word_t word,
  input  logic [1:0]      offset,
  input  vmem_pkg::eew_e  eew,
  output vmem_pkg::word_t element
);

  vmem_pkg::word_t shifted;

  // Byte offset times eight
  assign shifted = word >> {offset, 3'b000};

  always_comb begin
    case (eew)
      vmem_pkg::EEW8: begin
        element = {24'h0, shifted[7:0]};
      end
      vmem_pkg::EEW16: begin
        element = {16'h0, shifted[15:0]};
      end
      default: begin
        element = shifted;  // Full word, offset is zero here
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/vmem_memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

/*
  Vector memory stage
  Hands loads and stores to the address scheduler and stalls the
  execute stage until the scheduler is done. Lane 0 load data waits in
  a buffer while lane 1 is fetched. Results, ALU pass-through values
  and lane exceptions go to writeback through a pipeline latch with
  flush.
*/
module vmem_memory_stage (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 valid,
  input  logic                 load,
  input  logic                 store,
  input  vmem_pkg::eew_e       eew,
  input  vmem_pkg::lane_mask_t lane_mask,
  input  vmem_pkg::addr_t      addr0,
  input  vmem_pkg::addr_t      addr1,
  input  vmem_pkg::word_t      sdata0,
  input  vmem_pkg::word_t      sdata1,
  input  vmem_pkg::word_t      alu0,
  input  vmem_pkg::word_t      alu1,
  input  vmem_pkg::vreg_t      vd,
  input  logic                 flush,
  output logic                 stall,
  output logic                 wb_valid,
  output vmem_pkg::vreg_t      wb_vd,
  output vmem_pkg::word_t      wb_data0,
  output vmem_pkg::word_t      wb_data1,
  output vmem_pkg::lane_mask_t wb_mask,
  output vmem_pkg::lane_mask_t wb_exc,
  output logic                 cyc,
  output logic                 stb,
  output logic                 we,
  output vmem_pkg::addr_t      adr,
  output vmem_pkg::sel_t       sel,
  output vmem_pkg::word_t      dat_w,
  input  vmem_pkg::word_t      dat_r,
  input  logic                 ack
);

  logic                 pending;   // Memory op waiting on the scheduler
  logic                 start;
  logic                 busy;
  logic                 done;
  logic                 accept;
  logic                 arrived0;
  logic                 arrived1;
  vmem_pkg::lane_mask_t exc;
  vmem_pkg::lane_mask_t lane_ok;
  vmem_pkg::word_t      load_buf0;
  vmem_pkg::word_t      load_buf1;
  vmem_pkg::word_t      elem0;
  vmem_pkg::word_t      elem1;
  vmem_pkg::word_t      next_data0;
  vmem_pkg::word_t      next_data1;

  assign pending = valid & (load | store);
  assign start   = pending & ~busy;
  assign stall   = pending & ~done;   // Released in the done cycle
  assign accept  = valid & ~stall;

  vmem_address_scheduler u_sched (
    .CLK       (CLK),
    .nRST      (nRST),
    .start     (start),
    .load      (load),
    .store     (store),
    .eew       (eew),
    .lane_mask (lane_mask),
    .addr0     (addr0),
    .addr1     (addr1),
    .sdata0    (sdata0),
    .sdata1    (sdata1),
    .busy      (busy),
    .done      (done),
    .exc       (exc),
    .arrived0  (arrived0),
    .arrived1  (arrived1),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .sel       (sel),
    .dat_w     (dat_w),
    .ack       (ack)
  );

  // Load buffers, lane 1 is held too so the latch samples at done
  always_ff @(posedge CLK) begin
    if (arrived0) begin
      load_buf0 <= dat_r;
    end
    if (arrived1) begin
      load_buf1 <= dat_r;
    end
  end

  vmem_lane_align u_align0 (
    .word    (load_buf0),
    .offset  (addr0[1:0]),
    .eew     (eew),
    .element (elem0)
  );

  vmem_lane_align u_align1 (
    .word    (load_buf1),
    .offset  (addr1[1:0]),
    .eew     (eew),
    .element (elem1)
  );

  // Skipped lanes leave stale buffers behind, so zero them
  assign lane_ok = lane_mask & ~exc;

  always_comb begin
    if (load) begin
      next_data0 = lane_ok[0] ? elem0 : '0;
      next_data1 = lane_ok[1] ? elem1 : '0;
    end else if (store) begin
      next_data0 = '0;
      next_data1 = '0;
    end else begin
      next_data0 = alu0;     // Pass-through result
      next_data1 = alu1;
    end
  end

  // Writeback latch
  always_ff @(posedge CLK, negedge nRST) begin
    if (nRST == 0) begin
      wb_valid <= 1'b0;
      wb_exc   <= '0;
    end else if (flush) begin
      wb_valid <= 1'b0;
      wb_exc   <= '0;
    end else begin
      wb_valid <= accept;
      wb_exc   <= accept ? exc : '0;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      wb_vd    <= vd;
      wb_data0 <= next_data0;
      wb_data1 <= next_data1;
      wb_mask  <= lane_mask;
    end
  end

endmodule

`default_nettype wire

// File: logic/vmem_pkg.sv
`default_nettype none

/*
  Vector memory stage shared definitions
  Bus word and address types, lane count, element widths and the
  Wishbone byte select type, plus the element alignment rule used
  by the address scheduler.
*/
package vmem_pkg;

  localparam int WORD_W    = 32;          // Wishbone data width
  localparam int NUM_LANES = 2;           // Element lanes per operation
  localparam int SEL_W     = WORD_W / 8;  // One select bit per byte

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [31:0]          addr_t;   // Byte address
  typedef logic [NUM_LANES-1:0] lane_mask_t;
  typedef logic [4:0]           vreg_t;
  typedef logic [SEL_W-1:0]     sel_t;

  // Element width of a load or store
  typedef enum logic [1:0] {
    EEW8  = 2'd0,
    EEW16 = 2'd1,
    EEW32 = 2'd2
  } eew_e;

  // An element must sit on a multiple of its own size
  function automatic logic misaligned(addr_t addr, eew_e eew);
    logic result;
    case (eew)
      EEW8: begin
        result = 1'b0;
      end
      EEW16: begin
        result = addr[0];
      end
      default: begin
        result = |addr[1:0];
      end
    endcase
    return result;
  endfunction

endpackage

`default_nettype wire

// File: logic/vmem_scratchpad.sv
`timescale 1ns/1ps
`default_nettype none

/*
  Scratchpad data memory
  Word-addressed Wishbone classic slave in place of the data cache.
  Acknowledges a request after a fixed number of wait states, writes
  only the selected bytes and returns registered read data with ack.
*/
module vmem_scratchpad #(
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_STATES = 1
) (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            cyc,
  input  logic            stb,
  input  logic            we,
  input  vmem_pkg::addr_t adr,
  input  vmem_pkg::sel_t  sel,
  input  vmem_pkg::word_t dat_w,
  output vmem_pkg::word_t dat_r,
  output logic            ack
);

  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam int CNT_W = $clog2(WAIT_STATES + 1) + 1;

  vmem_pkg::word_t  mem [MEM_WORDS];
  logic [IDX_W-1:0] idx;
  logic [CNT_W-1:0] wait_cnt;
  logic             req;
  logic             fire;      // Access completes on this edge

  assign idx  = IDX_W'(adr[31:2] % MEM_WORDS);  // Wraps around the array
  assign req  = cyc & stb & ~ack;
  assign fire = req & (wait_cnt == CNT_W'(WAIT_STATES));

  always_ff @(posedge CLK, negedge nRST) begin
    if (nRST == 0) begin
      wait_cnt <= '0;
      ack      <= 1'b0;
    end else begin
      ack <= fire;
      if (req && !fire) begin
        wait_cnt <= wait_cnt + 1'b1;
      end else begin
        wait_cnt <= '0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (fire) begin
      dat_r <= mem[idx];
      if (we) begin
        for (int b = 0; b < $bits(vmem_pkg::sel_t); b++) begin
          if (sel[b]) begin
            mem[idx][8*b +: 8] <= dat_w[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/vmem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

/*
  Vector memory subsystem
  Memory stage and its scratchpad on a private Wishbone bus, so the
  stage can be run without a cache.
*/
module vmem_subsystem #(
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_STATES = 1
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 valid,
  input  logic                 load,
  input  logic                 store,
  input  vmem_pkg::eew_e       eew,
  input  vmem_pkg::lane_mask_t lane_mask,
  input  vmem_pkg::addr_t      addr0,
  input  vmem_pkg::addr_t      addr1,
  input  vmem_pkg::word_t      sdata0,
  input  vmem_pkg::word_t      sdata1,
  input  vmem_pkg::word_t      alu0,
  input  vmem_pkg::word_t      alu1,
  input  vmem_pkg::vreg_t      vd,
  input  logic                 flush,
  output logic                 stall,
  output logic                 wb_valid,
  output vmem_pkg::vreg_t      wb_vd,
  output vmem_pkg::word_t      wb_data0,
  output vmem_pkg::word_t      wb_data1,
  output vmem_pkg::lane_mask_t wb_mask,
  output vmem_pkg::lane_mask_t wb_exc
);

  // Wishbone between stage and scratchpad
  logic            cyc;
  logic            stb;
  logic            we;
  logic            ack;
  vmem_pkg::addr_t adr;
  vmem_pkg::sel_t  sel;
  vmem_pkg::word_t dat_w;
  vmem_pkg::word_t dat_r;

  vmem_memory_stage u_stage (
    .CLK       (CLK),
    .nRST      (nRST),
    .valid     (valid),
    .load      (load),
    .store     (store),
    .eew       (eew),
    .lane_mask (lane_mask),
    .addr0     (addr0),
    .addr1     (addr1),
    .sdata0    (sdata0),
    .sdata1    (sdata1),
    .alu0      (alu0),
    .alu1      (alu1),
    .vd        (vd),
    .flush     (flush),
    .stall     (stall),
    .wb_valid  (wb_valid),
    .wb_vd     (wb_vd),
    .wb_data0  (wb_data0),
    .wb_data1  (wb_data1),
    .wb_mask   (wb_mask),
    .wb_exc    (wb_exc),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .sel       (sel),
    .dat_w     (dat_w),
    .dat_r     (dat_r),
    .ack       (ack)
  );

  vmem_scratchpad #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) u_spad (
    .CLK   (CLK),
    .nRST  (nRST),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .sel   (sel),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack)
  );

endmodule

`default_nettype wire
